/* sim/row_fetch_tests.txt */
# layer line: ix pox k s p rows bursts
# burst line: row start end reg_start reg_end west_pad east_pad slab
40 40 3 1 0 4 8
0 0 31 1 32 0 0 0
0 32 39 33 42 0 2 0
1 0 31 1 32 0 0 0
1 32 39 33 42 0 2 0
2 0 31 1 32 0 0 0
2 32 39 33 42 0 2 0
3 0 31 1 32 0 0 0
3 32 39 33 42 0 2 0
40 16 3 1 1 1 3
0 0 31 1 33 1 0 0
0 16 31 1 17 0 0 1
0 32 39 1 18 0 9 1
48 28 7 1 0 1 3
0 0 31 1 32 0 0 0
0 32 47 33 48 0 0 0
0 28 47 1 34 0 14 0
8 8 3 2 1 3 3
0 0 7 1 17 1 8 0
1 0 7 1 17 1 8 0
2 0 7 1 17 1 8 0

/* sim.f */
+incdir+include
src/layer_cfg_pkg.sv
src/fetch_cmd_pkg.sv
src/loop_tiling.sv
src/conv_row.sv
src/line_buffer_select.sv
src/row_fetch_top.sv
sim/tb_row_fetch.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_row_fetch -f sim.f

out=$(./obj_dir/Vtb_row_fetch)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1

/* sim/tb_row_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "row_fetch_settings.svh"

module tb_row_fetch;

   logic                   clk;
   logic                   reset;
   logic                   start;
   layer_cfg_pkg::dim_t    cfg_ix, cfg_pox, cfg_rows;
   layer_cfg_pkg::ksp_t    cfg_k, cfg_s, cfg_p;
   logic                   cmd_valid;
   fetch_cmd_pkg::buf_id_t cmd_buf;
   fetch_cmd_pkg::idx_t    cmd_row, cmd_start, cmd_end, cmd_reg_start, cmd_reg_end;
   fetch_cmd_pkg::pad_t    cmd_west_pad, cmd_east_pad, cmd_slab;
   logic                   done;

   // seven words per layer and eight per expected burst
   int layer_q[$];
   int burst_q[$];
   int mismatches = 0;
   int failures = 0;
   int cycles = 0;
   int cycle_limit = 0;

   row_fetch_top u_row_fetch_top (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .cfg_ix        (cfg_ix),
      .cfg_pox       (cfg_pox),
      .cfg_k         (cfg_k),
      .cfg_s         (cfg_s),
      .cfg_p         (cfg_p),
      .cfg_rows      (cfg_rows),
      .cmd_valid     (cmd_valid),
      .cmd_buf       (cmd_buf),
      .cmd_row       (cmd_row),
      .cmd_start     (cmd_start),
      .cmd_end       (cmd_end),
      .cmd_reg_start (cmd_reg_start),
      .cmd_reg_end   (cmd_reg_end),
      .cmd_west_pad  (cmd_west_pad),
      .cmd_east_pad  (cmd_east_pad),
      .cmd_slab      (cmd_slab),
      .done          (done)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the layers did not finish", cycles);
         $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
         $display("sim failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   task automatic check_value(input string field, input int got, input int exp);
      assert (got == exp) else begin
         mismatches++;
         $display("Mismatch at %0t: %s is %0d, expected %0d", $time, field, got, exp);
      end
   endtask

   task automatic check_rule(input bit ok, input string what);
      assert (ok) else begin
         failures++;
         $display("at %0t: %s", $time, what);
      end
   endtask

   task automatic compare_burst(input int idx);
      int row;
      row = burst_q[idx*8];
      check_value("cmd_buf", int'(cmd_buf), row % `BUFFERS_NUM);
      check_value("cmd_row", int'(cmd_row), row);
      check_value("cmd_start", int'(cmd_start), burst_q[idx*8+1]);
      check_value("cmd_end", int'(cmd_end), burst_q[idx*8+2]);
      check_value("cmd_reg_start", int'(cmd_reg_start), burst_q[idx*8+3]);
      check_value("cmd_reg_end", int'(cmd_reg_end), burst_q[idx*8+4]);
      check_value("cmd_west_pad", int'(cmd_west_pad), burst_q[idx*8+5]);
      check_value("cmd_east_pad", int'(cmd_east_pad), burst_q[idx*8+6]);
      check_value("cmd_slab", int'(cmd_slab), burst_q[idx*8+7]);
      check_rule(int'(cmd_end) - int'(cmd_start) < `PIXELS_IN_ROW,
                 "a burst spans more than one row word");
   endtask

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   task automatic read_tests(input int fd);
      string skip;
      int v[8];
      int code;
      int i;
      int n;
      int count;
      // two comment lines name the columns
      code = $fgets(skip, fd);
      code = $fgets(skip, fd);
      while ($fscanf(fd, "%d %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5],
                     v[6]) == 7) begin
         count = v[6];
         for (i = 0; i < 7; i++) begin
            layer_q.push_back(v[i]);
         end
         for (n = 0; n < count; n++) begin
            code = $fscanf(fd, "%d %d %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4],
                           v[5], v[6], v[7]);
            check_rule(code == 8, "the tests file ends inside a burst list");
            for (i = 0; i < 8; i++) begin
               burst_q.push_back(v[i]);
            end
         end
      end
   endtask

   // tiles in a layer, ox = 1, 1 + pox, ... up to ix on every row
   function automatic int tiles_of(input int t);
      return ((layer_q[t*7] + layer_q[t*7+1] - 1) / layer_q[t*7+1]) * layer_q[t*7+5];
   endfunction

   task automatic pulse_reset();
      reset = 1'b1;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      check_rule(!cmd_valid && !done, "cmd_valid or done is high after reset");
   endtask

   task automatic drive_layer(input int t);
      @(negedge clk);
      cfg_ix   = layer_cfg_pkg::dim_t'(layer_q[t*7]);
      cfg_pox  = layer_cfg_pkg::dim_t'(layer_q[t*7+1]);
      cfg_k    = layer_cfg_pkg::ksp_t'(layer_q[t*7+2]);
      cfg_s    = layer_cfg_pkg::ksp_t'(layer_q[t*7+3]);
      cfg_p    = layer_cfg_pkg::ksp_t'(layer_q[t*7+4]);
      cfg_rows = layer_cfg_pkg::dim_t'(layer_q[t*7+5]);
      start    = 1'b1;
      @(negedge clk);
      start    = 1'b0;
   endtask

   // start a layer and stop once its second input row is out and the rotation left buffer 0
   task automatic abort_layer(input int t);
      if (layer_q[t*7+5] > 1) begin
         drive_layer(t);
         while (!(cmd_valid && cmd_row != '0)) begin
            @(negedge clk);
         end
      end
   endtask

   task automatic run_layer(input int t, input int base);
      int nb;
      int got;
      int cyc;
      int gap;
      bit prev_valid;
      bit finished;
      nb = layer_q[t*7+6];
      drive_layer(t);
      cyc        = 1;
      got        = 0;
      prev_valid = 1'b0;
      finished   = 1'b0;
      while (!finished) begin
         if (cmd_valid) begin
            check_rule(got < nb, "more bursts than the tests file lists");
            if (got == 0) begin
               check_rule(cyc == 2, "first burst is not 2 cycles after start");
            end
            if (got < nb) begin
               compare_burst(base + got);
            end
            got++;
         end
         if (done) begin
            check_rule(prev_valid && !cmd_valid && got == nb,
                       "done is not one cycle after the last burst");
            finished = 1'b1;
         end
         prev_valid = cmd_valid;
         @(negedge clk);
         cyc++;
      end
      // nothing may come out in the idle gap before the next start
      gap = $urandom % 6;
      repeat (gap + 1) begin
         check_rule(!cmd_valid && !done, "cmd_valid or done after the end of the layer");
         @(negedge clk);
      end
   endtask

   initial begin
      int fd;
      int base;
      int total;
      int n_layers;
      int t;
      reset    = 1'b1;
      start    = 1'b0;
      cfg_ix   = '0;
      cfg_pox  = '0;
      cfg_k    = '0;
      cfg_s    = '0;
      cfg_p    = '0;
      cfg_rows = '0;
      void'($urandom(7));
      fd = $fopen("sim/row_fetch_tests.txt", "r");
      if (fd == 0) begin
         failures++;
         $display("could not open sim/row_fetch_tests.txt");
      end else begin
         read_tests(fd);
         $fclose(fd);
      end
      n_layers = layer_q.size() / 7;
      check_rule(n_layers > 0, "the tests file holds no layer");
      total = 0;
      for (t = 0; t < n_layers; t++) begin
         total += layer_q[t*7+6] + tiles_of(t);
      end
      cycle_limit = 4 * total + 200;

      pulse_reset();
      base = 0;
      for (t = 0; t < n_layers; t++) begin
         // a reset in the middle of the last layer brings the rotation back to buffer 0
         if (t > 0 && t == n_layers - 1) begin
            abort_layer(t);
            pulse_reset();
         end
         run_layer(t, base);
         base += layer_q[t*7+6];
      end

      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/row_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module row_fetch_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  layer_cfg_pkg::dim_t    cfg_ix,
   input  layer_cfg_pkg::dim_t    cfg_pox,
   input  layer_cfg_pkg::ksp_t    cfg_k,
   input  layer_cfg_pkg::ksp_t    cfg_s,
   input  layer_cfg_pkg::ksp_t    cfg_p,
   input  layer_cfg_pkg::dim_t    cfg_rows,
   output logic                   cmd_valid,
   output fetch_cmd_pkg::buf_id_t cmd_buf,
   output fetch_cmd_pkg::idx_t    cmd_row,
   output fetch_cmd_pkg::idx_t    cmd_start,
   output fetch_cmd_pkg::idx_t    cmd_end,
   output fetch_cmd_pkg::idx_t    cmd_reg_start,
   output fetch_cmd_pkg::idx_t    cmd_reg_end,
   output fetch_cmd_pkg::pad_t    cmd_west_pad,
   output fetch_cmd_pkg::pad_t    cmd_east_pad,
   output fetch_cmd_pkg::pad_t    cmd_slab,
   output logic                   done
);

   logic                en, row_last, loop_tiling_add_end, conv_row_add_end, seg_valid;
   layer_cfg_pkg::dim_t row_y, ox_start, next_ox_start;
   fetch_cmd_pkg::pad_t west_pad, slab_num, east_pad;
   fetch_cmd_pkg::idx_t row_idx, row_start_idx, row_end_idx;
   fetch_cmd_pkg::idx_t reg_start_idx, reg_end_idx;

   //////////////////////////////////////////////////
   // tiling controller, row walker, buffer tagging
   //////////////////////////////////////////////////

   loop_tiling u_loop_tiling (
      .clk                 (clk),
      .reset               (reset),
      .start               (start),
      .cfg_ix              (cfg_ix),
      .cfg_pox             (cfg_pox),
      .cfg_rows            (cfg_rows),
      .conv_row_add_end    (conv_row_add_end),
      .en                  (en),
      .row_y               (row_y),
      .ox_start            (ox_start),
      .next_ox_start       (next_ox_start),
      .row_last            (row_last),
      .loop_tiling_add_end (loop_tiling_add_end)
   );

   conv_row u_conv_row (
      .clk                 (clk),
      .reset               (reset),
      .en                  (en),
      .loop_tiling_add_end (loop_tiling_add_end),
      .row_y               (row_y),
      .ix                  (cfg_ix),
      .ox_start            (ox_start),
      .next_ox_start       (next_ox_start),
      .pox                 (cfg_pox),
      .k                   (cfg_k),
      .s                   (cfg_s),
      .p                   (cfg_p),
      .seg_valid           (seg_valid),
      .west_pad            (west_pad),
      .slab_num            (slab_num),
      .east_pad            (east_pad),
      .row_idx             (row_idx),
      .row_start_idx       (row_start_idx),
      .row_end_idx         (row_end_idx),
      .reg_start_idx       (reg_start_idx),
      .reg_end_idx         (reg_end_idx),
      .conv_row_add_end    (conv_row_add_end)
   );

   line_buffer_select u_line_buffer_select (
      .clk                 (clk),
      .reset               (reset),
      .seg_valid           (seg_valid),
      .row_last            (row_last),
      .conv_row_add_end    (conv_row_add_end),
      .loop_tiling_add_end (loop_tiling_add_end),
      .west_pad            (west_pad),
      .slab_num            (slab_num),
      .east_pad            (east_pad),
      .row_idx             (row_idx),
      .row_start_idx       (row_start_idx),
      .row_end_idx         (row_end_idx),
      .reg_start_idx       (reg_start_idx),
      .reg_end_idx         (reg_end_idx),
      .cmd_valid           (cmd_valid),
      .cmd_buf             (cmd_buf),
      .cmd_row             (cmd_row),
      .cmd_start           (cmd_start),
      .cmd_end             (cmd_end),
      .cmd_reg_start       (cmd_reg_start),
      .cmd_reg_end         (cmd_reg_end),
      .cmd_west_pad        (cmd_west_pad),
      .cmd_east_pad        (cmd_east_pad),
      .cmd_slab            (cmd_slab),
      .done                (done)
   );

endmodule

`default_nettype wire

/* src/line_buffer_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "row_fetch_settings.svh"

module line_buffer_select (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  seg_valid,
   input  logic                  row_last,
   input  logic                  conv_row_add_end,
   input  logic                  loop_tiling_add_end,
   input  fetch_cmd_pkg::pad_t   west_pad,
   input  fetch_cmd_pkg::pad_t   slab_num,
   input  fetch_cmd_pkg::pad_t   east_pad,
   input  fetch_cmd_pkg::idx_t   row_idx,
   input  fetch_cmd_pkg::idx_t   row_start_idx,
   input  fetch_cmd_pkg::idx_t   row_end_idx,
   input  fetch_cmd_pkg::idx_t   reg_start_idx,
   input  fetch_cmd_pkg::idx_t   reg_end_idx,
   output logic                  cmd_valid,
   output fetch_cmd_pkg::buf_id_t cmd_buf,
   output fetch_cmd_pkg::idx_t   cmd_row,
   output fetch_cmd_pkg::idx_t   cmd_start,
   output fetch_cmd_pkg::idx_t   cmd_end,
   output fetch_cmd_pkg::idx_t   cmd_reg_start,
   output fetch_cmd_pkg::idx_t   cmd_reg_end,
   output fetch_cmd_pkg::pad_t   cmd_west_pad,
   output fetch_cmd_pkg::pad_t   cmd_east_pad,
   output fetch_cmd_pkg::pad_t   cmd_slab,
   output logic                  done
);

   localparam fetch_cmd_pkg::buf_id_t last_buf = `BUFFERS_NUM - 1;

   fetch_cmd_pkg::buf_id_t buf_sel;

   // one input row per buffer, each layer begins on buffer 0
   always_ff @(posedge clk) begin
      if (reset || loop_tiling_add_end) begin
         buf_sel <= '0;
      end else if (conv_row_add_end && row_last) begin
         buf_sel <= (buf_sel == last_buf) ? '0 : buf_sel + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_valid <= 1'b0;
         done      <= 1'b0;
      end else begin
         cmd_valid <= seg_valid;
         done      <= loop_tiling_add_end;
      end
   end

   always_ff @(posedge clk) begin
      if (seg_valid) begin
         cmd_buf       <= buf_sel;
         cmd_row       <= row_idx;
         cmd_start     <= row_start_idx;
         cmd_end       <= row_end_idx;
         cmd_reg_start <= reg_start_idx;
         cmd_reg_end   <= reg_end_idx;
         cmd_west_pad  <= west_pad;
         cmd_east_pad  <= east_pad;
         cmd_slab      <= slab_num;
      end
   end

endmodule

`default_nettype wire

/* src/conv_row.sv */
`timescale 1ns/1ps
`default_nettype none

`include "row_fetch_settings.svh"

module conv_row (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 en,
   input  logic                 loop_tiling_add_end,
   input  layer_cfg_pkg::dim_t  row_y,
   input  layer_cfg_pkg::dim_t  ix,
   input  layer_cfg_pkg::dim_t  ox_start,
   input  layer_cfg_pkg::dim_t  next_ox_start,
   input  layer_cfg_pkg::dim_t  pox,
   input  layer_cfg_pkg::ksp_t  k,
   input  layer_cfg_pkg::ksp_t  s,
   input  layer_cfg_pkg::ksp_t  p,
   output logic                 seg_valid,
   output fetch_cmd_pkg::pad_t  west_pad,
   output fetch_cmd_pkg::pad_t  slab_num,
   output fetch_cmd_pkg::pad_t  east_pad,
   output fetch_cmd_pkg::idx_t  row_idx,
   output fetch_cmd_pkg::idx_t  row_start_idx,
   output fetch_cmd_pkg::idx_t  row_end_idx,
   output fetch_cmd_pkg::idx_t  reg_start_idx,
   output fetch_cmd_pkg::idx_t  reg_end_idx,
   output logic                 conv_row_add_end
);

   localparam fetch_cmd_pkg::idx_t word_px   = `PIXELS_IN_ROW;
   localparam fetch_cmd_pkg::idx_t word_mask = `PIXELS_IN_ROW - 1;

   fetch_cmd_pkg::idx_t k_ext, p_ext, pox_m1, p_plus_1, p_plus_ix;
   fetch_cmd_pkg::idx_t ix_start, next_ix_start, ix_end, ix_end_min0, ix_end_min;
   fetch_cmd_pkg::idx_t left_pad, right_pad, right_pad_min, overlap;
   fetch_cmd_pkg::idx_t row_start_fix, row_end_min_fix, row_end_fix;
   fetch_cmd_pkg::idx_t adr, reg_from, seg_base, seg_start, seg_last, seg_end, reg_to;
   logic                active1, active2, need_second, seg_done;
   logic                loop1_last, loop2_last, first_burst;

   // last pixel of the word holding x, capped at the row end
   function automatic fetch_cmd_pkg::idx_t word_end(input fetch_cmd_pkg::idx_t x,
                                                    input fetch_cmd_pkg::idx_t last);
      fetch_cmd_pkg::idx_t up;
      if ((x & word_mask) == '0) begin
         up = x - 1'b1;
      end else begin
         up = (x & ~word_mask) + word_mask;
      end
      return (up > last) ? last : up;
   endfunction

   //////////////////////////////////////////////////
   // tile span in padded input coordinates
   //////////////////////////////////////////////////

   assign k_ext     = fetch_cmd_pkg::idx_t'(k);
   assign p_ext     = fetch_cmd_pkg::idx_t'(p);
   assign pox_m1    = pox - 1'b1;
   assign p_plus_1  = p_ext + 1'b1;
   assign p_plus_ix = p_ext + ix;

   // (ox - 1) * s + 1, only strides 1 and 2
   assign ix_start      = (s == 4'd1) ? ox_start :
                          (s == 4'd2) ? (ox_start << 1) - 1'b1 : '0;
   assign next_ix_start = (s == 4'd1) ? next_ox_start :
                          (s == 4'd2) ? (next_ox_start << 1) - 1'b1 : '0;

   // ix_start + (pox - 1) * s + k - 1
   assign ix_end = (s == 4'd1) ? ix_start + k_ext + pox_m1 - 1'b1 :
                   (s == 4'd2) ? ix_start + k_ext + (pox_m1 << 1) - 1'b1 : '0;

   // part of the span not shared with the following tile
   assign ix_end_min0 = (s == 4'd1) ? next_ix_start :
                        (s == 4'd2) ? next_ix_start - 1'b1 : '0;
   assign ix_end_min  = (ix_end_min0 > ix_end) ? ix_end : ix_end_min0;

   assign left_pad      = (ix_start <= p_ext) ? p_ext - ix_start + 1'b1 : '0;
   assign right_pad     = (ix_end > p_plus_ix) ? ix_end - p_plus_ix : '0;
   assign right_pad_min = (ix_end_min > p_plus_ix) ? ix_end_min - p_plus_ix : '0;

   // columns past the pad region carry p pixels of overlap
   assign overlap = (ix_start <= p_plus_1) ? '0 : p_ext;

   // clipped span in row pixel indices, ends rounded up to whole words
   assign row_start_fix   = ix_start + left_pad - p_plus_1 + overlap;
   assign row_end_min_fix = word_end(ix_end_min - right_pad_min - p_plus_1, ix - 1'b1);
   assign row_end_fix     = word_end(ix_end - right_pad - p_plus_1, ix - 1'b1);
   assign need_second     = row_end_fix > row_end_min_fix;

   //////////////////////////////////////////////////
   // burst walk
   //////////////////////////////////////////////////

   // second loop restarts one pixel past the first loop's end
   assign seg_base  = active2 ? row_end_min_fix : row_start_fix;
   assign seg_last  = active2 ? row_end_fix : row_end_min_fix;
   assign seg_start = seg_base + adr;
   assign seg_end   = (seg_start + word_px - 1'b1 > seg_last) ? seg_last :
                      seg_start + word_px - 1'b1;
   assign seg_done  = (adr + word_px) > (seg_last - seg_base);

   assign loop1_last  = active1 && seg_done;
   assign loop2_last  = active2 && seg_done;
   assign first_burst = active1 && (adr == '0);
   assign reg_to      = reg_from + (seg_end - seg_start);

   always_ff @(posedge clk) begin
      if (reset || loop_tiling_add_end) begin
         active1 <= 1'b0;
         active2 <= 1'b0;
      end else if (en) begin
         active1 <= 1'b1;
      end else if (loop1_last) begin
         active1 <= 1'b0;
         active2 <= need_second;
      end else if (loop2_last) begin
         active2 <= 1'b0;
      end
   end

   // registers fill on from the previous burst
   always_ff @(posedge clk) begin
      if (en) begin
         adr      <= '0;
         reg_from <= left_pad + overlap + 1'b1;
      end else if (seg_valid) begin
         adr      <= loop1_last ? fetch_cmd_pkg::idx_t'(1) : adr + word_px;
         reg_from <= reg_to + 1'b1;
      end
   end

   assign seg_valid        = active1 || active2;
   assign conv_row_add_end = (loop1_last && !need_second) || loop2_last;

   assign row_idx       = row_y;
   assign row_start_idx = seg_start;
   assign row_end_idx   = seg_end;
   assign west_pad      = first_burst ? fetch_cmd_pkg::pad_t'(left_pad) : '0;
   assign slab_num      = first_burst ? fetch_cmd_pkg::pad_t'(overlap) : '0;
   assign east_pad      = conv_row_add_end ? fetch_cmd_pkg::pad_t'(right_pad) : '0;
   assign reg_start_idx = first_burst ? fetch_cmd_pkg::idx_t'(1) : reg_from;
   assign reg_end_idx   = reg_to + fetch_cmd_pkg::idx_t'(east_pad);

endmodule

`default_nettype wire

/* src/loop_tiling.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_tiling (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  layer_cfg_pkg::dim_t cfg_ix,
   input  layer_cfg_pkg::dim_t cfg_pox,
   input  layer_cfg_pkg::dim_t cfg_rows,
   input  logic                conv_row_add_end,
   output logic                en,
   output layer_cfg_pkg::dim_t row_y,
   output layer_cfg_pkg::dim_t ox_start,
   output layer_cfg_pkg::dim_t next_ox_start,
   output logic                row_last,
   output logic                loop_tiling_add_end
);

   localparam logic [1:0] st_idle  = 2'd0;
   localparam logic [1:0] st_issue = 2'd1;
   localparam logic [1:0] st_wait  = 2'd2;

   logic [1:0]          state;
   layer_cfg_pkg::dim_t ox_q;
   layer_cfg_pkg::dim_t row_q;
   logic                tile_last;
   logic                layer_last;

   // column start of the following tile, not wrapped
   assign next_ox_start = ox_q + cfg_pox;
   assign tile_last     = next_ox_start > cfg_ix;
   assign layer_last    = tile_last && (row_q == cfg_rows - 1'b1);

   assign ox_start = ox_q;
   assign row_y    = row_q;
   assign row_last = tile_last;

   // first tile launches straight from start, later ones from the issue state
   assign en = ((state == st_idle) && start) || (state == st_issue);

   //////////////////////////////////////////////////
   // tile and row walk
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state               <= st_idle;
         ox_q                <= 1;
         row_q               <= '0;
         loop_tiling_add_end <= 1'b0;
      end else begin
         loop_tiling_add_end <= 1'b0;
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_wait;
               end
            end
            st_issue: begin
               state <= st_wait;
            end
            st_wait: begin
               if (conv_row_add_end) begin
                  if (layer_last) begin
                     // back to the first tile, ready for the next layer
                     state               <= st_idle;
                     ox_q                <= 1;
                     row_q               <= '0;
                     loop_tiling_add_end <= 1'b1;
                  end else if (tile_last) begin
                     state <= st_issue;
                     ox_q  <= 1;
                     row_q <= row_q + 1'b1;
                  end else begin
                     state <= st_issue;
                     ox_q  <= next_ox_start;
                  end
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/fetch_cmd_pkg.sv */
`default_nettype none

`include "row_fetch_settings.svh"

package fetch_cmd_pkg;

   // input pixel or register-file index
   typedef logic [`IDX_W-1:0] idx_t;

   // pad or slab count
   typedef logic [3:0] pad_t;

   // line buffer number
   typedef logic [$clog2(`BUFFERS_NUM)-1:0] buf_id_t;

endpackage

`default_nettype wire

/* src/layer_cfg_pkg.sv */
`default_nettype none

`include "row_fetch_settings.svh"

package layer_cfg_pkg;

   // pixel coordinate or count
   // used for ix, pox, ox_start, row_y and rows
   typedef logic [`IDX_W-1:0] dim_t;

   // kernel size, stride or padding
   typedef logic [3:0] ksp_t;

endpackage

`default_nettype wire

/* include/row_fetch_settings.svh */
`ifndef ROW_FETCH_SETTINGS_SVH
`define ROW_FETCH_SETTINGS_SVH

//////////////////////////////////////////////////
// fetch geometry
//////////////////////////////////////////////////

// pixels held by one row-buffer word, power of two
`define PIXELS_IN_ROW 32

// line buffers in the rotation
`define BUFFERS_NUM 3

// pixel and register index width
`define IDX_W 16

`endif
